// ==== axi_wr_mon_cg.f ====
verilog/axi_wr_mon_pkg.sv
verilog/skid_buffer.sv
verilog/wr_txn_tracker.sv
verilog/clock_gate_ctrl.sv
verilog/axi_wr_mon_cg.sv
verif/axi_wr_mon_checker.sv
verif/axi_wr_mon_cg_tb.sv

// ==== verif/axi_wr_mon_cg_tb.sv ====
`timescale 1ns/1ns

module axi_wr_mon_cg_tb;
    import axi_wr_mon_pkg::*;

    localparam int MAX_TESTS    = 32;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_COUNT   = 6;
    localparam int TIMEOUT      = 20;

    logic                aclk;
    logic                rst_n;
    logic                cfg_cg_enable;
    logic [CG_CNT_W-1:0] cfg_cg_idle_count;
    logic                cfg_monitor_enable;
    logic [15:0]         cfg_timeout_cycles;
    aw_beat_t            fub_aw;
    logic                fub_awvalid;
    logic                fub_awready;
    w_beat_t             fub_w;
    logic                fub_wvalid;
    logic                fub_wready;
    b_beat_t             fub_b;
    logic                fub_bvalid;
    logic                fub_bready;
    aw_beat_t            m_aw;
    logic                m_awvalid;
    logic                m_awready;
    w_beat_t             m_w;
    logic                m_wvalid;
    logic                m_wready;
    b_beat_t             m_b;
    logic                m_bvalid;
    logic                m_bready;
    logic                monbus_valid;
    logic                monbus_ready;
    mon_packet_t         monbus_packet;
    logic                busy;
    logic [4:0]          active_transactions;
    logic [15:0]         error_count;
    logic [31:0]         transaction_count;
    logic                cg_gating;
    logic                cg_idle;

    logic                test_start;
    logic                test_end;
    logic [8*16-1:0]     exp_name;
    logic [8*4-1:0]      exp_op;
    aw_beat_t            exp_aw;
    logic [3:0][31:0]    exp_data;
    b_beat_t             exp_b;
    logic                exp_to;
    logic [3:0]          exp_type;
    int                  pkt_count;
    int                  pass_count;
    int                  fail_count;

    logic [8*16-1:0]     t_name  [MAX_TESTS];
    logic [8*4-1:0]      t_op    [MAX_TESTS];
    aw_beat_t            t_aw    [MAX_TESTS];
    logic [3:0][31:0]    t_data  [MAX_TESTS];
    b_beat_t             t_b     [MAX_TESTS];
    int                  t_delay [MAX_TESTS];
    logic                t_bp    [MAX_TESTS];
    logic                t_to    [MAX_TESTS];
    logic [3:0]          t_type  [MAX_TESTS];
    int                  num_tests;
    int                  cycles;
    int                  limit;
    logic                bp_on;
    logic [15:0]         lfsr;

    axi_wr_mon_cg DUT (.*);

    axi_wr_mon_checker chk (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // Monitor bus sink with random gaps in back-pressure tests
    always @(posedge aclk) begin
        #1;
        if (bp_on) begin
            monbus_ready = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end else begin
            monbus_ready = 1'b1;
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("run stopped after %0d cycles, a handshake or packet never arrived", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic tick();
        @(posedge aclk);
        #1;
    endtask

    task automatic load_tests();
        int              fd;
        int              n;
        int              id;
        int              len;
        int              resp;
        int              dly;
        int              bp;
        int              to;
        int              typ;
        logic [8*160-1:0] line;
        logic [8*16-1:0] name;
        logic [8*4-1:0]  op;
        logic [31:0]     addr;
        logic [31:0]     d0;
        logic [31:0]     d1;
        logic [31:0]     d2;
        logic [31:0]     d3;
        fd = $fopen("verif/axi_wr_mon_stimulus.txt", "r");
        if (fd == 0) begin
            return;
        end
        line = '0;
        while ($fgets(line, fd) != 0 && num_tests < MAX_TESTS) begin
            n = $sscanf(line, "%s %s %d %h %d %h %h %h %h %d %d %d %d %d",
                        op, name, id, addr, len, d0, d1, d2, d3, resp, dly, bp, to, typ);
            if (n == 14) begin
                t_name[num_tests]    = name;
                t_op[num_tests]      = op;
                t_aw[num_tests].id   = id;
                t_aw[num_tests].addr = addr;
                t_aw[num_tests].len  = len;
                t_data[num_tests]    = {d3, d2, d1, d0};
                t_b[num_tests].id    = id;
                t_b[num_tests].resp  = resp;
                t_delay[num_tests]   = dly;
                t_bp[num_tests]      = bp;
                t_to[num_tests]      = to;
                t_type[num_tests]    = typ;
                limit += len + 1 + dly + 50;
                num_tests++;
            end
            line = '0;
        end
        $fclose(fd);
    endtask

    task automatic send_aw(input int k);
        logic done;
        fub_aw = t_aw[k];
        fub_awvalid = 1'b1;
        do begin
            @(posedge aclk);
            done = fub_awready;
            #1;
        end while (!done);
        fub_awvalid = 1'b0;
    endtask

    task automatic send_w(input int k);
        logic done;
        for (int i = 0; i <= int'(t_aw[k].len); i++) begin
            fub_w.data = t_data[k][i];
            fub_w.strb = '1;
            fub_w.last = (i == int'(t_aw[k].len));
            fub_wvalid = 1'b1;
            do begin
                @(posedge aclk);
                done = fub_wready;
                #1;
            end while (!done);
        end
        fub_wvalid = 1'b0;
    endtask

    task automatic take_b();
        logic done;
        fub_bready = 1'b1;
        do begin
            @(posedge aclk);
            done = fub_bvalid;
            #1;
        end while (!done);
        fub_bready = 1'b0;
    endtask

    // Slave side answers once the address and the last data beat arrived
    task automatic answer_b(input int k);
        logic aw_seen;
        logic w_done;
        logic done;
        aw_seen = 1'b0;
        w_done = 1'b0;
        while (!(aw_seen && w_done)) begin
            @(posedge aclk);
            aw_seen = aw_seen || (m_awvalid && m_awready);
            w_done = w_done || (m_wvalid && m_wready && m_w.last);
            #1;
        end
        repeat (t_delay[k]) tick();
        m_b = t_b[k];
        m_bvalid = 1'b1;
        do begin
            @(posedge aclk);
            done = m_bready;
            #1;
        end while (!done);
        m_bvalid = 1'b0;
    endtask

    task automatic run_test(input int k);
        exp_name = t_name[k];
        exp_op = t_op[k];
        exp_aw = t_aw[k];
        exp_data = t_data[k];
        exp_b = t_b[k];
        exp_to = t_to[k];
        exp_type = t_type[k];
        bp_on = t_bp[k];
        cfg_cg_enable = (t_op[k] == "cg");
        test_start = 1'b1;
        tick();
        test_start = 1'b0;
        if (t_op[k] == "cg") begin
            while (!cg_gating) begin
                tick();
            end
        end else if (t_op[k] == "ncg") begin
            repeat (IDLE_COUNT + 8) tick();
        end
        fork
            begin
                fork
                    send_aw(k);
                    send_w(k);
                join
                take_b();
            end
            answer_b(k);
        join
        while (pkt_count < int'(t_to[k]) + 1) begin
            tick();
        end
        // A few more cycles so a duplicate packet would still be caught
        repeat (4) tick();
        test_end = 1'b1;
        tick();
        test_end = 1'b0;
    endtask

    initial begin
        rst_n = 1'b0;
        cfg_cg_enable = 1'b0;
        cfg_cg_idle_count = IDLE_COUNT;
        cfg_monitor_enable = 1'b1;
        cfg_timeout_cycles = TIMEOUT;
        fub_aw = '0;
        fub_awvalid = 1'b0;
        fub_w = '0;
        fub_wvalid = 1'b0;
        fub_bready = 1'b0;
        m_awready = 1'b1;
        m_wready = 1'b1;
        m_b = '0;
        m_bvalid = 1'b0;
        monbus_ready = 1'b1;
        test_start = 1'b0;
        test_end = 1'b0;
        exp_name = '0;
        exp_op = '0;
        exp_aw = '0;
        exp_data = '0;
        exp_b = '0;
        exp_to = 1'b0;
        exp_type = '0;
        bp_on = 1'b0;
        lfsr = 16'd10;
        num_tests = 0;
        cycles = 0;
        limit = RESET_CYCLES + 10;
        load_tests();
        if (num_tests == 0) begin
            $display("no tests could be read from the stimulus file");
        end else begin
            repeat (RESET_CYCLES) @(posedge aclk);
            #1;
            rst_n = 1'b1;
            tick();
            for (int k = 0; k < num_tests; k++) begin
                run_test(k);
            end
        end
        $display("pass count %0d, fail count %0d", pass_count, fail_count);
        if (num_tests > 0 && fail_count == 0 && pass_count == num_tests) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verif/axi_wr_mon_checker.sv ====
`timescale 1ns/1ns

module axi_wr_mon_checker (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  axi_wr_mon_pkg::aw_beat_t    m_aw,
    input  logic                        m_awvalid,
    input  logic                        m_awready,
    input  axi_wr_mon_pkg::w_beat_t     m_w,
    input  logic                        m_wvalid,
    input  logic                        m_wready,
    input  axi_wr_mon_pkg::b_beat_t     m_b,
    input  logic                        m_bvalid,
    input  logic                        m_bready,
    input  axi_wr_mon_pkg::b_beat_t     fub_b,
    input  logic                        fub_bvalid,
    input  logic                        fub_bready,
    input  axi_wr_mon_pkg::mon_packet_t monbus_packet,
    input  logic                        monbus_valid,
    input  logic                        monbus_ready,
    input  logic [4:0]                  active_transactions,
    input  logic [15:0]                 error_count,
    input  logic [31:0]                 transaction_count,
    input  logic                        busy,
    input  logic                        cg_gating,
    input  logic                        cg_idle,
    input  logic [15:0]                 cfg_timeout_cycles,
    input  logic                        test_start,
    input  logic                        test_end,
    input  logic [8*16-1:0]             exp_name,
    input  logic [8*4-1:0]              exp_op,
    input  axi_wr_mon_pkg::aw_beat_t    exp_aw,
    input  logic [3:0][31:0]            exp_data,
    input  axi_wr_mon_pkg::b_beat_t     exp_b,
    input  logic                        exp_to,
    input  logic [3:0]                  exp_type,
    output int                          pkt_count,
    output int                          pass_count,
    output int                          fail_count
);
    import axi_wr_mon_pkg::*;

    int          cyc;
    int          aw_cyc;
    int          lat;
    int          beat;
    int          errs;
    int          aw_hs;
    int          b_hs;
    int          err_hs;
    int          aw_test;
    logic        gate_seen;
    logic        idle_seen;
    logic        cnt_bad;
    logic        flag_bad;
    mon_packet_t exp_pkt;

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("FAILED %0s %0s expected %h actual %h", exp_name, what, exp, act);
            errs++;
        end
    endtask

    task automatic check_packet();
        if (exp_to && pkt_count == 0) begin
            check("timeout type", PKT_TIMEOUT, monbus_packet.pkt_type);
            check("timeout id", exp_aw.id, monbus_packet.id);
            check("timeout addr", exp_aw.addr, monbus_packet.addr);
            check("timeout unit", UNIT_ID, monbus_packet.unit_id);
            if (monbus_packet.latency <= cfg_timeout_cycles) begin
                $display("FAILED %0s timeout latency expected above %0d actual %0d",
                         exp_name, cfg_timeout_cycles, monbus_packet.latency);
                errs++;
            end
        end else if (pkt_count == int'(exp_to)) begin
            // Latency is the AW to B handshake distance seen on the m side
            exp_pkt = {exp_type, UNIT_ID, exp_b.id, exp_b.resp, 16'(lat), exp_aw.addr};
            check("packet", exp_pkt, monbus_packet);
        end else begin
            $display("%0s got an extra monitor packet %h", exp_name, monbus_packet);
            errs++;
        end
        pkt_count++;
    endtask

    task automatic finish_test();
        if (pkt_count != int'(exp_to) + 1) begin
            $display("FAILED %0s packet count expected %0d actual %0d",
                     exp_name, int'(exp_to) + 1, pkt_count);
            errs++;
        end
        if (aw_test != 1) begin
            $display("FAILED %0s aw count expected 1 actual %0d", exp_name, aw_test);
            errs++;
        end
        if (beat != int'(exp_aw.len) + 1) begin
            $display("FAILED %0s w beats expected %0d actual %0d",
                     exp_name, int'(exp_aw.len) + 1, beat);
            errs++;
        end
        if (busy) begin
            $display("busy still high at the end of %0s", exp_name);
            errs++;
        end
        if ((exp_op == "cg" || exp_op == "ncg") && !idle_seen) begin
            $display("idle flag never rose before %0s", exp_name);
            errs++;
        end
        if (exp_op == "cg" && !gate_seen) begin
            $display("clock gate never closed before %0s", exp_name);
            errs++;
        end
        if (exp_op == "ncg" && gate_seen) begin
            $display("clock gate closed in %0s although gating was disabled", exp_name);
            errs++;
        end
        if (errs == 0) begin
            $display("%0s: ok", exp_name);
            pass_count++;
        end else begin
            $display("%0s: %0d errors", exp_name, errs);
            fail_count++;
        end
    endtask

    always @(posedge aclk) begin
        cyc++;
        if (test_start) begin
            beat = 0;
            errs = 0;
            pkt_count = 0;
            aw_test = 0;
            gate_seen = 1'b0;
            idle_seen = 1'b0;
            cnt_bad = 1'b0;
            flag_bad = 1'b0;
        end
        if (rst_n) begin
            if (cg_gating) begin
                gate_seen = 1'b1;
            end
            if (cg_idle) begin
                idle_seen = 1'b1;
            end
            // Gate closes only when idle, and idle never coexists with an open write
            if (!flag_bad && cg_gating && !cg_idle) begin
                $display("%0s: clock gate closed without the idle flag", exp_name);
                errs++;
                flag_bad = 1'b1;
            end
            if (!flag_bad && busy && cg_idle) begin
                $display("%0s: idle flag high while the monitor is busy", exp_name);
                errs++;
                flag_bad = 1'b1;
            end
            if (!flag_bad && aw_hs != b_hs && !busy) begin
                $display("%0s: busy low while a write is outstanding", exp_name);
                errs++;
                flag_bad = 1'b1;
            end
            // Status counters against handshakes seen before this edge
            if (!cnt_bad && (active_transactions != 5'(aw_hs - b_hs) ||
                             error_count != 16'(err_hs) || transaction_count != 32'(b_hs))) begin
                $display("FAILED %0s counters expected %0d/%0d/%0d actual %0d/%0d/%0d",
                         exp_name, aw_hs - b_hs, err_hs, b_hs,
                         active_transactions, error_count, transaction_count);
                errs++;
                cnt_bad = 1'b1;
            end
            if (m_awvalid && m_awready) begin
                check("aw", exp_aw, m_aw);
                aw_cyc = cyc;
                aw_hs++;
                aw_test++;
            end
            if (m_wvalid && m_wready) begin
                check("w", {exp_data[beat], {STRB_W{1'b1}}, beat == int'(exp_aw.len)}, m_w);
                beat++;
            end
            if (m_bvalid && m_bready) begin
                lat = cyc - aw_cyc;
                b_hs++;
                if (m_b.resp != RESP_OKAY) begin
                    err_hs++;
                end
            end
            if (fub_bvalid && fub_bready) begin
                check("b", exp_b, fub_b);
            end
            if (monbus_valid && monbus_ready) begin
                check_packet();
            end
        end
        if (test_end) begin
            finish_test();
        end
    end

endmodule

// ==== verif/axi_wr_mon_stimulus.txt ====
# op name id addr len d0 d1 d2 d3 bresp delay bp exp_to exp_type
# op wr plain write, cg gate closed first, ncg idle with gating off; type 1 compl 2 error 3 timeout
wr single_okay 3 00001000 0 11111111 00000000 00000000 00000000 0 2 0 0 1
wr burst4_okay 5 00002040 3 a0a0a001 a0a0a002 a0a0a003 a0a0a004 0 4 0 0 1
wr slverr 7 00003000 1 cafe0001 cafe0002 00000000 00000000 2 3 0 0 2
wr decerr 9 00004000 0 deadbeef 00000000 00000000 00000000 3 1 0 0 2
wr timeout_okay 2 00005000 1 55aa0001 55aa0002 00000000 00000000 0 60 0 1 1
wr timeout_err 4 00006000 0 77770000 00000000 00000000 00000000 2 55 0 1 2
wr bp_okay 6 00007000 2 10000001 10000002 10000003 00000000 0 2 1 0 1
wr bp_error 8 00008000 3 20000001 20000002 20000003 20000004 2 5 1 0 2
wr bp_timeout 10 00009000 0 30303030 00000000 00000000 00000000 0 60 1 1 1
cg gate_wake 11 0000a000 1 40000001 40000002 00000000 00000000 0 3 0 0 1
cg gate_wake_err 12 0000b000 0 50000001 00000000 00000000 00000000 3 2 1 0 2
ncg no_gate 13 0000c000 0 60000001 00000000 00000000 00000000 0 2 0 0 1
wr zero_delay 0 0000d000 0 70000001 00000000 00000000 00000000 0 0 0 0 1
wr id15_burst 15 0000f000 3 80000001 80000002 80000003 80000004 0 8 1 0 1

// ==== verilog/axi_wr_mon_cg.sv ====
`timescale 1ns/1ns

module axi_wr_mon_cg (
    input  logic                                aclk,
    input  logic                                rst_n,

    input  logic                                cfg_cg_enable,
    input  logic [axi_wr_mon_pkg::CG_CNT_W-1:0] cfg_cg_idle_count,
    input  logic                                cfg_monitor_enable,
    input  logic [15:0]                         cfg_timeout_cycles,

    // Initiator side
    input  axi_wr_mon_pkg::aw_beat_t            fub_aw,
    input  logic                                fub_awvalid,
    output logic                                fub_awready,
    input  axi_wr_mon_pkg::w_beat_t             fub_w,
    input  logic                                fub_wvalid,
    output logic                                fub_wready,
    output axi_wr_mon_pkg::b_beat_t             fub_b,
    output logic                                fub_bvalid,
    input  logic                                fub_bready,

    // Interconnect side
    output axi_wr_mon_pkg::aw_beat_t            m_aw,
    output logic                                m_awvalid,
    input  logic                                m_awready,
    output axi_wr_mon_pkg::w_beat_t             m_w,
    output logic                                m_wvalid,
    input  logic                                m_wready,
    input  axi_wr_mon_pkg::b_beat_t             m_b,
    input  logic                                m_bvalid,
    output logic                                m_bready,

    output logic                                monbus_valid,
    input  logic                                monbus_ready,
    output axi_wr_mon_pkg::mon_packet_t         monbus_packet,

    output logic                                busy,
    output logic [4:0]                          active_transactions,
    output logic [15:0]                         error_count,
    output logic [31:0]                         transaction_count,
    output logic                                cg_gating,
    output logic                                cg_idle
);
    import axi_wr_mon_pkg::*;

    logic        gated_aclk;
    logic        activity;
    logic        aw_in_ready;
    logic        w_in_ready;
    logic        b_in_ready;
    logic        trk_b_ready;
    mon_packet_t trk_pkt;
    logic        trk_pkt_valid;
    logic        trk_pkt_ready;

    // Beats still held in the buffers also keep the clock running
    assign activity = fub_awvalid || fub_wvalid || fub_bready || m_bvalid || busy ||
                      monbus_valid || m_awvalid || m_wvalid || fub_bvalid;

    assign fub_awready = aw_in_ready && !cg_gating;
    assign fub_wready  = w_in_ready && !cg_gating;
    assign m_bready    = b_in_ready && trk_b_ready && !cg_gating;

    clock_gate_ctrl cg_ctrl (
        .clk_in(aclk), .rst_n(rst_n),
        .cfg_cg_enable(cfg_cg_enable), .cfg_cg_idle_count(cfg_cg_idle_count),
        .activity(activity),
        .clk_out(gated_aclk), .gating(cg_gating), .idle(cg_idle)
    );

    skid_buffer #(.payload_t(aw_beat_t)) aw_buf (
        .aclk(gated_aclk), .rst_n(rst_n),
        .in_data(fub_aw), .in_valid(fub_awvalid), .in_ready(aw_in_ready),
        .out_data(m_aw), .out_valid(m_awvalid), .out_ready(m_awready)
    );

    skid_buffer #(.payload_t(w_beat_t)) w_buf (
        .aclk(gated_aclk), .rst_n(rst_n),
        .in_data(fub_w), .in_valid(fub_wvalid), .in_ready(w_in_ready),
        .out_data(m_w), .out_valid(m_wvalid), .out_ready(m_wready)
    );

    // Tracker may hold off B while its packet register is full
    skid_buffer #(.payload_t(b_beat_t)) b_buf (
        .aclk(gated_aclk), .rst_n(rst_n),
        .in_data(m_b), .in_valid(m_bvalid && trk_b_ready), .in_ready(b_in_ready),
        .out_data(fub_b), .out_valid(fub_bvalid), .out_ready(fub_bready)
    );

    wr_txn_tracker tracker (
        .aclk(gated_aclk), .rst_n(rst_n),
        .aw(m_aw), .aw_fire(m_awvalid && m_awready),
        .b(m_b), .b_valid(m_bvalid && b_in_ready), .b_ready(trk_b_ready),
        .cfg_monitor_enable(cfg_monitor_enable), .cfg_timeout_cycles(cfg_timeout_cycles),
        .pkt(trk_pkt), .pkt_valid(trk_pkt_valid), .pkt_ready(trk_pkt_ready),
        .busy(busy), .active_transactions(active_transactions),
        .error_count(error_count), .transaction_count(transaction_count)
    );

    skid_buffer #(.payload_t(mon_packet_t)) pkt_buf (
        .aclk(gated_aclk), .rst_n(rst_n),
        .in_data(trk_pkt), .in_valid(trk_pkt_valid), .in_ready(trk_pkt_ready),
        .out_data(monbus_packet), .out_valid(monbus_valid), .out_ready(monbus_ready)
    );

endmodule

// ==== verilog/axi_wr_mon_pkg.sv ====
package axi_wr_mon_pkg;

    // AXI widths
    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // One tracker slot per id
    localparam int NUM_SLOTS = 1 << ID_W;

    localparam logic [5:0] UNIT_ID   = 6'h05;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Idle counter width of the clock gate
    localparam int CG_CNT_W = 4;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } aw_beat_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } b_beat_t;

    typedef enum logic [3:0] {
        PKT_COMPL   = 4'd1,
        PKT_ERROR   = 4'd2,
        PKT_TIMEOUT = 4'd3
    } mon_pkt_type_e;

    // 64-bit monitor bus word
    typedef struct packed {
        mon_pkt_type_e     pkt_type;
        logic [5:0]        unit_id;
        logic [ID_W-1:0]   id;
        logic [1:0]        resp;
        logic [15:0]       latency;
        logic [ADDR_W-1:0] addr;
    } mon_packet_t;

endpackage

// ==== verilog/clock_gate_ctrl.sv ====
`timescale 1ns/1ns

module clock_gate_ctrl (
    input  logic                                clk_in,
    input  logic                                rst_n,
    input  logic                                cfg_cg_enable,
    input  logic [axi_wr_mon_pkg::CG_CNT_W-1:0] cfg_cg_idle_count,
    input  logic                                activity,
    output logic                                clk_out,
    output logic                                gating,
    output logic                                idle
);
    import axi_wr_mon_pkg::*;

    logic [CG_CNT_W-1:0] idle_cnt;
    logic                idle_q;
    logic                clk_en;
    logic                clk_en_latch;

    // Idle counter on the free clock restarts on any activity
    always_ff @(posedge clk_in) begin
        if (!rst_n || activity) begin
            idle_cnt <= '0;
            idle_q   <= 1'b0;
        end else if (idle_cnt < cfg_cg_idle_count) begin
            idle_cnt <= idle_cnt + 1'b1;
            idle_q   <= (idle_cnt == cfg_cg_idle_count - 1'b1);
        end else begin
            idle_q <= 1'b1;
        end
    end

    // Gate stays open in reset and opens as soon as activity shows up
    assign clk_en = !rst_n || !(cfg_cg_enable && idle_q && !activity);

    // Enable only changes while the clock is low, so clk_out has no glitch
    always_latch begin
        if (!clk_in) begin
            clk_en_latch <= clk_en;
        end
    end

    assign clk_out = clk_in && clk_en_latch;
    assign gating  = !clk_en_latch;
    assign idle    = idle_q;

endmodule

// ==== verilog/skid_buffer.sv ====
`timescale 1ns/1ns

module skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     aclk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // entry0 drives the output, entry1 catches a beat under back-pressure
    payload_t entry0;
    payload_t entry1;
    logic     valid0;
    logic     valid1;
    logic     push;
    logic     pop;

    assign push      = in_valid && in_ready;
    assign pop       = valid0 && out_ready;
    assign in_ready  = !valid1;
    assign out_valid = valid0;
    assign out_data  = entry0;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end else if (push && !pop) begin
            if (valid0) begin
                valid1 <= 1'b1;
            end else begin
                valid0 <= 1'b1;
            end
        end else if (pop && !push) begin
            if (valid1) begin
                valid1 <= 1'b0;
            end else begin
                valid0 <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (pop && valid1) begin
            entry0 <= entry1;
        end else if (push && (!valid0 || pop)) begin
            entry0 <= in_data;
        end
        if (push && valid0 && !pop) begin
            entry1 <= in_data;
        end
    end

endmodule

// ==== verilog/wr_txn_tracker.sv ====
`timescale 1ns/1ns

module wr_txn_tracker (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  axi_wr_mon_pkg::aw_beat_t    aw,
    input  logic                        aw_fire,
    input  axi_wr_mon_pkg::b_beat_t     b,
    input  logic                        b_valid,
    output logic                        b_ready,
    input  logic                        cfg_monitor_enable,
    input  logic [15:0]                 cfg_timeout_cycles,
    output axi_wr_mon_pkg::mon_packet_t pkt,
    output logic                        pkt_valid,
    input  logic                        pkt_ready,
    output logic                        busy,
    output logic [4:0]                  active_transactions,
    output logic [15:0]                 error_count,
    output logic [31:0]                 transaction_count
);
    import axi_wr_mon_pkg::*;

    logic [NUM_SLOTS-1:0] slot_open;
    logic [NUM_SLOTS-1:0] slot_to;
    logic [ADDR_W-1:0]    slot_addr [NUM_SLOTS];
    logic [15:0]          slot_age  [NUM_SLOTS];
    logic [ID_W-1:0]      scan_idx;
    logic                 hold_valid;
    mon_packet_t          hold_q;
    mon_packet_t          hold_d;
    logic                 hold_free;
    logic                 b_fire;
    logic                 b_error;
    logic                 to_hit;
    logic                 to_load;
    logic                 load;

    // Holding register frees up in the same cycle it drains
    assign hold_free = !hold_valid || pkt_ready;
    assign b_ready   = hold_free;
    assign b_fire    = b_valid && b_ready;
    assign b_error   = b.resp != RESP_OKAY;

    // Completion wins over the timeout scan
    assign to_hit  = slot_open[scan_idx] && !slot_to[scan_idx] &&
                     (slot_age[scan_idx] > cfg_timeout_cycles);
    assign to_load = cfg_monitor_enable && to_hit && hold_free && !b_fire;
    assign load    = (cfg_monitor_enable && b_fire) || to_load;

    assign pkt       = hold_q;
    assign pkt_valid = hold_valid;
    assign busy      = (|slot_open) || hold_valid;

    always_comb begin
        hold_d.unit_id = UNIT_ID;
        if (b_fire) begin
            hold_d.pkt_type = b_error ? PKT_ERROR : PKT_COMPL;
            hold_d.id       = b.id;
            hold_d.resp     = b.resp;
            hold_d.latency  = slot_age[b.id];
            hold_d.addr     = slot_addr[b.id];
        end else begin
            hold_d.pkt_type = PKT_TIMEOUT;
            hold_d.id       = scan_idx;
            hold_d.resp     = RESP_OKAY;
            hold_d.latency  = slot_age[scan_idx];
            hold_d.addr     = slot_addr[scan_idx];
        end
    end

    // Age starts at 1 so it equals the AW-to-B cycle count at the B edge
    always_ff @(posedge aclk) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (aw_fire && (aw.id == ID_W'(i))) begin
                slot_addr[i] <= aw.addr;
                slot_age[i]  <= 16'd1;
            end else if (slot_open[i] && (slot_age[i] != 16'hffff)) begin
                slot_age[i] <= slot_age[i] + 16'd1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            slot_open           <= '0;
            slot_to             <= '0;
            scan_idx            <= '0;
            hold_valid          <= 1'b0;
            active_transactions <= '0;
            error_count         <= '0;
            transaction_count   <= '0;
        end else begin
            scan_idx <= scan_idx + 1'b1;
            if (to_load) begin
                slot_to[scan_idx] <= 1'b1;
            end
            if (b_fire) begin
                slot_open[b.id]   <= 1'b0;
                slot_to[b.id]     <= 1'b0;
                transaction_count <= transaction_count + 32'd1;
                if (b_error) begin
                    error_count <= error_count + 16'd1;
                end
            end
            // A new AW on the same id reopens the slot
            if (aw_fire) begin
                slot_open[aw.id] <= 1'b1;
                slot_to[aw.id]   <= 1'b0;
            end
            active_transactions <= active_transactions + 5'(aw_fire) - 5'(b_fire);
            if (load) begin
                hold_valid <= 1'b1;
            end else if (pkt_ready) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            hold_q <= hold_d;
        end
    end

endmodule
